// ==== logic/helix_pkg.sv ====
package helix_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths and address map
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int OFFSET_W = 12;

  localparam logic [ADDR_W-1:0] SOC_CTRL_BASE = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE     = 32'h4000_1000;

  // SoC controller registers
  localparam logic [OFFSET_W-1:0] GPR0_OFS      = 12'h000;
  localparam logic [OFFSET_W-1:0] GPR1_OFS      = 12'h004;
  localparam logic [OFFSET_W-1:0] BOOT_MODE_OFS = 12'h008;

  // UART registers
  localparam logic [OFFSET_W-1:0] UART_TXDATA_OFS = 12'h000;
  localparam logic [OFFSET_W-1:0] UART_STATUS_OFS = 12'h004;

  // Short bit time keeps simulation quick
  localparam int UART_CLKS_PER_BIT = 8;
  localparam int BAUD_CNT_W        = $clog2(UART_CLKS_PER_BIT);

  ////////////////////////////////////////////////////////////
  // Bus payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Full address, as seen by the link decoder
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
  } link_req_t;

  // Window offset only, as seen by a device
  typedef struct packed {
    logic [OFFSET_W-1:0] offset;
    logic                write;
    logic [DATA_W-1:0]   wdata;
  } dev_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } link_rsp_t;

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT_ACK,
    PORT_RELEASE,
    PORT_DONE
  } port_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_state_e;

endpackage

// ==== logic/apb_slave_port.sv ====
module apb_slave_port (
  input  logic                 periphl_clk_i,
  input  logic                 rst_n_i,
  input  helix_pkg::apb_req_t  apb_req_i,
  output helix_pkg::apb_rsp_t  apb_rsp_o,
  output logic                 link_valid_o,
  output helix_pkg::link_req_t link_req_o,
  input  logic                 link_ack_i,
  input  helix_pkg::link_rsp_t link_rsp_i
);

  helix_pkg::port_state_e state_q;
  helix_pkg::link_req_t   req_q;
  helix_pkg::link_rsp_t   rsp_q;
  logic                   valid_q;
  logic                   accept;
  logic                   ack_seen;
  logic                   done;

  // Access phase of a new APB transfer
  assign accept = (state_q == helix_pkg::PORT_IDLE) &&
                  apb_req_i.psel && apb_req_i.penable;

  assign ack_seen = (state_q == helix_pkg::PORT_WAIT_ACK) && link_ack_i;
  assign done     = (state_q == helix_pkg::PORT_DONE);

  ////////////////////////////////////////////////////////////
  // Four-phase handshake towards the link
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      state_q <= helix_pkg::PORT_IDLE;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        helix_pkg::PORT_IDLE: begin
          if (accept) begin
            valid_q <= 1'b1;
            state_q <= helix_pkg::PORT_WAIT_ACK;
          end
        end
        helix_pkg::PORT_WAIT_ACK: begin
          // Response is valid with ack, so req may drop now
          if (link_ack_i) begin
            valid_q <= 1'b0;
            state_q <= helix_pkg::PORT_RELEASE;
          end
        end
        helix_pkg::PORT_RELEASE: begin
          if (!link_ack_i) begin
            state_q <= helix_pkg::PORT_DONE;
          end
        end
        helix_pkg::PORT_DONE: begin
          state_q <= helix_pkg::PORT_IDLE;
        end
        default: begin
          state_q <= helix_pkg::PORT_IDLE;
        end
      endcase
    end
  end

  // Request held from accept until the next transfer
  always_ff @(posedge periphl_clk_i) begin
    if (accept) begin
      req_q.addr  <= apb_req_i.paddr;
      req_q.write <= apb_req_i.pwrite;
      req_q.wdata <= apb_req_i.pwdata;
    end
  end

  // Read data and error captured on the ack edge
  always_ff @(posedge periphl_clk_i) begin
    if (ack_seen) begin
      rsp_q <= link_rsp_i;
    end
  end

  assign link_valid_o = valid_q;
  assign link_req_o   = req_q;

  ////////////////////////////////////////////////////////////
  // APB response
  ////////////////////////////////////////////////////////////

  // pready lasts only the DONE cycle
  always_comb begin
    apb_rsp_o.prdata  = rsp_q.rdata;
    apb_rsp_o.pready  = done;
    apb_rsp_o.pslverr = done & rsp_q.err;
  end

endmodule

// ==== logic/periph_link.sv ====
module periph_link (
  input  logic                 periphl_clk_i,
  input  logic                 rst_n_i,
  // From the APB port
  input  logic                 link_valid_i,
  input  helix_pkg::link_req_t link_req_i,
  output logic                 link_ack_o,
  output helix_pkg::link_rsp_t link_rsp_o,
  // SoC controller window
  output logic                 ctrl_valid_o,
  output helix_pkg::dev_req_t  ctrl_req_o,
  input  logic                 ctrl_ack_i,
  input  helix_pkg::link_rsp_t ctrl_rsp_i,
  // UART window
  output logic                 uart_valid_o,
  output helix_pkg::dev_req_t  uart_req_o,
  input  logic                 uart_ack_i,
  input  helix_pkg::link_rsp_t uart_rsp_i
);

  logic                 sel_ctrl;
  logic                 sel_uart;
  logic                 ack_d;
  logic                 ack_q;
  helix_pkg::link_rsp_t rsp_d;
  helix_pkg::link_rsp_t rsp_q;
  helix_pkg::dev_req_t  dev_req;

  ////////////////////////////////////////////////////////////
  // Window decode
  ////////////////////////////////////////////////////////////

  // Compare the upper address bits against each 4 KiB base
  assign sel_ctrl = link_req_i.addr[helix_pkg::ADDR_W-1:helix_pkg::OFFSET_W] ==
                    helix_pkg::SOC_CTRL_BASE[helix_pkg::ADDR_W-1:helix_pkg::OFFSET_W];
  assign sel_uart = link_req_i.addr[helix_pkg::ADDR_W-1:helix_pkg::OFFSET_W] ==
                    helix_pkg::UART_BASE[helix_pkg::ADDR_W-1:helix_pkg::OFFSET_W];

  // Both devices see the same offset request
  always_comb begin
    dev_req.offset = link_req_i.addr[helix_pkg::OFFSET_W-1:0];
    dev_req.write  = link_req_i.write;
    dev_req.wdata  = link_req_i.wdata;
  end

  assign ctrl_req_o   = dev_req;
  assign uart_req_o   = dev_req;
  assign ctrl_valid_o = link_valid_i & sel_ctrl;
  assign uart_valid_o = link_valid_i & sel_uart;

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  // Unmapped window answers by itself, one cycle behind req
  always_comb begin
    if (sel_ctrl) begin
      ack_d = ctrl_ack_i;
      rsp_d = ctrl_rsp_i;
    end else if (sel_uart) begin
      ack_d = uart_ack_i;
      rsp_d = uart_rsp_i;
    end else begin
      ack_d       = link_valid_i;
      rsp_d.rdata = '0;
      rsp_d.err   = 1'b1;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    rsp_q <= rsp_d;
  end

  assign link_ack_o = ack_q;
  assign link_rsp_o = rsp_q;

endmodule

// ==== logic/soc_ctrl_regs.sv ====
module soc_ctrl_regs (
  input  logic                         periphl_clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_valid_i,
  input  helix_pkg::dev_req_t          req_i,
  output logic                         ack_o,
  output helix_pkg::link_rsp_t         rsp_o,
  input  logic                         boot_mode_i,
  output logic [helix_pkg::DATA_W-1:0] gpr0_o,
  output logic [helix_pkg::DATA_W-1:0] gpr1_o
);

  logic                         ack_q;
  logic                         access;
  logic                         wr_ok;
  logic                         rd_err;
  logic [helix_pkg::DATA_W-1:0] rd_data;
  logic [helix_pkg::DATA_W-1:0] gpr0_q;
  logic [helix_pkg::DATA_W-1:0] gpr1_q;
  helix_pkg::link_rsp_t         rsp_q;

  // First cycle of a request, before ack has risen
  assign access = req_valid_i & ~ack_q;

  ////////////////////////////////////////////////////////////
  // Offset decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (req_i.offset)
      helix_pkg::GPR0_OFS:      rd_data = gpr0_q;
      helix_pkg::GPR1_OFS:      rd_data = gpr1_q;
      helix_pkg::BOOT_MODE_OFS: rd_data = {{(helix_pkg::DATA_W-1){1'b0}}, boot_mode_i};
      default:                  rd_err  = 1'b1;
    endcase
  end

  // Only the two GPRs take writes, boot mode is a status bit
  assign wr_ok = (req_i.offset == helix_pkg::GPR0_OFS) ||
                 (req_i.offset == helix_pkg::GPR1_OFS);

  ////////////////////////////////////////////////////////////
  // Registers and handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      gpr0_q <= '0;
      gpr1_q <= '0;
    end else begin
      ack_q <= req_valid_i;
      if (access && req_i.write) begin
        if (req_i.offset == helix_pkg::GPR0_OFS) begin
          gpr0_q <= req_i.wdata;
        end
        if (req_i.offset == helix_pkg::GPR1_OFS) begin
          gpr1_q <= req_i.wdata;
        end
      end
    end
  end

  // Response settles together with ack
  always_ff @(posedge periphl_clk_i) begin
    if (access) begin
      rsp_q.rdata <= req_i.write ? '0 : rd_data;
      rsp_q.err   <= req_i.write ? ~wr_ok : rd_err;
    end
  end

  assign ack_o  = ack_q;
  assign rsp_o  = rsp_q;
  assign gpr0_o = gpr0_q;
  assign gpr1_o = gpr1_q;

endmodule

// ==== logic/uart_tx.sv ====
module uart_tx (
  input  logic                 periphl_clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  helix_pkg::dev_req_t  req_i,
  output logic                 ack_o,
  output helix_pkg::link_rsp_t rsp_o,
  output logic                 tx_o
);

  helix_pkg::uart_state_e           state_q;
  helix_pkg::link_rsp_t             rsp_q;
  logic                             ack_q;
  logic                             access;
  logic                             busy;
  logic                             is_txdata;
  logic                             is_status;
  logic                             load;
  logic                             bit_end;
  logic [helix_pkg::BAUD_CNT_W-1:0] baud_q;
  logic [2:0]                       bit_q;
  logic [7:0]                       shift_q;

  assign access    = req_valid_i & ~ack_q;
  assign busy      = state_q != helix_pkg::TX_IDLE;
  assign is_txdata = req_i.offset == helix_pkg::UART_TXDATA_OFS;
  assign is_status = req_i.offset == helix_pkg::UART_STATUS_OFS;

  // a byte is only taken while the shifter is idle
  assign load    = access & req_i.write & is_txdata & ~busy;
  assign bit_end = baud_q == helix_pkg::BAUD_CNT_W'(helix_pkg::UART_CLKS_PER_BIT - 1);

  ////////////////////////////////////////////////////////////
  // Register access
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_valid_i;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (access) begin
      rsp_q.rdata <= '0;
      rsp_q.err   <= 1'b0;
      if (req_i.write) begin
        // Busy writes are dropped and flagged
        if (!is_txdata || busy) begin
          rsp_q.err <= 1'b1;
        end
      end else if (is_status) begin
        rsp_q.rdata <= {{(helix_pkg::DATA_W-1){1'b0}}, busy};
      end else begin
        rsp_q.err <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Serial shifter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i) begin
    if (!rst_n_i) begin
      state_q <= helix_pkg::TX_IDLE;
      baud_q  <= '0;
      bit_q   <= '0;
    end else begin
      baud_q <= bit_end ? '0 : baud_q + 1'b1;
      case (state_q)
        helix_pkg::TX_IDLE: begin
          baud_q <= '0;
          if (load) begin
            state_q <= helix_pkg::TX_START;
          end
        end
        helix_pkg::TX_START: begin
          if (bit_end) begin
            bit_q   <= '0;
            state_q <= helix_pkg::TX_DATA;
          end
        end
        helix_pkg::TX_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            // LSB first, eight bits
            if (bit_q == 3'd7) begin
              state_q <= helix_pkg::TX_STOP;
            end
          end
        end
        helix_pkg::TX_STOP: begin
          if (bit_end) begin
            state_q <= helix_pkg::TX_IDLE;
          end
        end
        default: begin
          state_q <= helix_pkg::TX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (load) begin
      shift_q <= req_i.wdata[7:0];
    end else if ((state_q == helix_pkg::TX_DATA) && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // Line idles high
  always_comb begin
    case (state_q)
      helix_pkg::TX_START: tx_o = 1'b0;
      helix_pkg::TX_DATA:  tx_o = shift_q[0];
      default:             tx_o = 1'b1;
    endcase
  end

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

endmodule

// ==== logic/periph_soc_top.sv ====
module periph_soc_top (
  input  logic                         periphl_clk_i,
  input  logic                         rst_n_i,
  input  helix_pkg::apb_req_t          apb_req_i,
  output helix_pkg::apb_rsp_t          apb_rsp_o,
  input  logic                         boot_mode_i,
  output logic                         uart_tx_o,
  output logic [helix_pkg::DATA_W-1:0] gpr0_o,
  output logic [helix_pkg::DATA_W-1:0] gpr1_o
);

  logic                 link_valid;
  helix_pkg::link_req_t link_req;
  logic                 link_ack;
  helix_pkg::link_rsp_t link_rsp;

  logic                 ctrl_valid;
  helix_pkg::dev_req_t  ctrl_req;
  logic                 ctrl_ack;
  helix_pkg::link_rsp_t ctrl_rsp;

  logic                 uart_valid;
  helix_pkg::dev_req_t  uart_req;
  logic                 uart_ack;
  helix_pkg::link_rsp_t uart_rsp;

  ////////////////////////////////////////////////////////////
  // APB port and peripheral link
  ////////////////////////////////////////////////////////////

  apb_slave_port u_apb_port (
    .periphl_clk_i(periphl_clk_i),
    .rst_n_i      (rst_n_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .link_valid_o (link_valid),
    .link_req_o   (link_req),
    .link_ack_i   (link_ack),
    .link_rsp_i   (link_rsp)
  );

  periph_link u_periph_link (
    .periphl_clk_i(periphl_clk_i),
    .rst_n_i      (rst_n_i),
    .link_valid_i (link_valid),
    .link_req_i   (link_req),
    .link_ack_o   (link_ack),
    .link_rsp_o   (link_rsp),
    .ctrl_valid_o (ctrl_valid),
    .ctrl_req_o   (ctrl_req),
    .ctrl_ack_i   (ctrl_ack),
    .ctrl_rsp_i   (ctrl_rsp),
    .uart_valid_o (uart_valid),
    .uart_req_o   (uart_req),
    .uart_ack_i   (uart_ack),
    .uart_rsp_i   (uart_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Devices
  ////////////////////////////////////////////////////////////

  soc_ctrl_regs u_soc_ctrl (
    .periphl_clk_i(periphl_clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (ctrl_valid),
    .req_i        (ctrl_req),
    .ack_o        (ctrl_ack),
    .rsp_o        (ctrl_rsp),
    .boot_mode_i  (boot_mode_i),
    .gpr0_o       (gpr0_o),
    .gpr1_o       (gpr1_o)
  );

  uart_tx u_uart_tx (
    .periphl_clk_i(periphl_clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (uart_valid),
    .req_i        (uart_req),
    .ack_o        (uart_ack),
    .rsp_o        (uart_rsp),
    .tx_o         (uart_tx_o)
  );

endmodule

// ==== sim/periph_soc_asserts.sv ====
module periph_link_asserts (
  input logic                 periphl_clk_i,
  input logic                 rst_n_i,
  input logic                 link_valid_i,
  input helix_pkg::link_req_t link_req_i,
  input logic                 link_ack_i,
  input logic                 ctrl_valid_i,
  input logic                 ctrl_ack_i,
  input logic                 uart_valid_i,
  input logic                 uart_ack_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read by the testbench at the end of the run
  int unsigned error_count = 0;

  ////////////////////////////////////////////////////////////
  // Four-phase handshake on the link
  ////////////////////////////////////////////////////////////

  req_held: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    link_valid_i && !link_ack_i |=> link_valid_i)
    else begin
      error_count++;
      $error("link req dropped before ack");
    end

  payload_stable: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    link_valid_i && !link_ack_i |=> $stable(link_req_i))
    else begin
      error_count++;
      $error("link payload changed while req was high");
    end

  ack_held: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    link_ack_i && link_valid_i |=> link_ack_i)
    else begin
      error_count++;
      $error("link ack fell before req fell");
    end

  // New req only once the previous ack is gone
  req_after_ack: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    $rose(link_valid_i) |-> !link_ack_i)
    else begin
      error_count++;
      $error("link req rose while ack was still high");
    end

  // A device stays engaged from its req rising until its ack falls
  one_device: assert property (@(posedge periphl_clk_i) disable iff (!rst_n_i)
    $onehot0({ctrl_valid_i | ctrl_ack_i, uart_valid_i | uart_ack_i}))
    else begin
      error_count++;
      $error("more than one device handshake active");
    end

endmodule

bind periph_link periph_link_asserts handshake_checks (
  .periphl_clk_i(periphl_clk_i),
  .rst_n_i      (rst_n_i),
  .link_valid_i (link_valid_i),
  .link_req_i   (link_req_i),
  .link_ack_i   (link_ack_o),
  .ctrl_valid_i (ctrl_valid_o),
  .ctrl_ack_i   (ctrl_ack_i),
  .uart_valid_i (uart_valid_o),
  .uart_ack_i   (uart_ack_i)
);

// ==== sim/periph_soc_tb.sv ====
module periph_soc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_UART
  } op_e;

  typedef struct packed {
    op_e                          kind;
    logic [helix_pkg::ADDR_W-1:0] addr;
    logic [helix_pkg::DATA_W-1:0] wdata;
    logic                         boot_mode;
    logic [helix_pkg::DATA_W-1:0] exp_rdata;
    logic                         exp_err;
  } entry_t;

  logic                         clk;
  logic                         rst_n;
  logic                         boot_mode;
  logic                         uart_tx;
  logic [helix_pkg::DATA_W-1:0] gpr0;
  logic [helix_pkg::DATA_W-1:0] gpr1;
  helix_pkg::apb_req_t          apb_req;
  helix_pkg::apb_rsp_t          apb_rsp;

  entry_t     table_q[$];
  logic       table_ready = 1'b0;
  int         uart_entries = 0;
  int         rx_count = 0;
  logic [7:0] rx_byte;
  logic       rx_stop;

  periph_soc_top UUT (
    .periphl_clk_i(clk),
    .rst_n_i      (rst_n),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (apb_rsp),
    .boot_mode_i  (boot_mode),
    .uart_tx_o    (uart_tx),
    .gpr0_o       (gpr0),
    .gpr1_o       (gpr1)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [helix_pkg::DATA_W-1:0] expected,
                            input logic [helix_pkg::DATA_W-1:0] actual);
    if (actual !== expected)
      abort_run($sformatf("mismatch at %0t: %s expected %h, got %h",
                          $time, name, expected, actual));
  endtask

  task automatic check_err(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("mismatch at %0t: %s expected %b, got %b",
                          $time, name, expected, actual));
  endtask

  task automatic check_serial(input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected)
      abort_run($sformatf("mismatch at %0t: uart_tx_o byte expected %h, got %h",
                          $time, expected, actual));
  endtask

  function automatic logic [helix_pkg::ADDR_W-1:0] addr_of(
    input logic [helix_pkg::ADDR_W-1:0] base, input logic [helix_pkg::OFFSET_W-1:0] ofs);
    return base + helix_pkg::ADDR_W'(ofs);
  endfunction

  ////////////////////////////////////////////////////////////
  // APB master and UART sequences
  ////////////////////////////////////////////////////////////

  // Setup cycle, then access cycles until pready, all on falling edges
  task automatic apb_access(input logic write, input logic [helix_pkg::ADDR_W-1:0] addr,
                            input logic [helix_pkg::DATA_W-1:0] wdata,
                            output logic [helix_pkg::DATA_W-1:0] rdata, output logic err);
    int   waited;
    logic got;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    got    = 1'b0;
    waited = 0;
    while (!got && waited < 64) begin
      @(negedge clk);
      waited++;
      got = apb_rsp.pready;
    end
    if (!got)
      abort_run($sformatf("APB transfer to %h got no pready within 64 cycles", addr));
    rdata           = apb_rsp.prdata;
    err             = apb_rsp.pslverr;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic send_uart_byte(input logic [7:0] tx_byte);
    logic [helix_pkg::ADDR_W-1:0] txdata_addr;
    logic [helix_pkg::ADDR_W-1:0] status_addr;
    logic [helix_pkg::DATA_W-1:0] rdata;
    logic                         err;
    int                           frames_before;
    int                           waited;
    txdata_addr   = addr_of(helix_pkg::UART_BASE, helix_pkg::UART_TXDATA_OFS);
    status_addr   = addr_of(helix_pkg::UART_BASE, helix_pkg::UART_STATUS_OFS);
    frames_before = rx_count;
    apb_access(1'b1, txdata_addr, {24'h0, tx_byte}, rdata, err);
    check_err("pslverr on TXDATA write", 1'b0, err);
    // Frame is running now
    apb_access(1'b0, status_addr, '0, rdata, err);
    check_data("prdata of STATUS while busy", 32'h1, rdata);
    check_err("pslverr on STATUS read", 1'b0, err);
    apb_access(1'b1, txdata_addr, {24'h0, ~tx_byte}, rdata, err);
    check_err("pslverr on busy TXDATA write", 1'b1, err);
    waited = 0;
    while (rx_count == frames_before && waited < 12 * helix_pkg::UART_CLKS_PER_BIT) begin
      @(negedge clk);
      waited++;
    end
    if (rx_count == frames_before)
      abort_run("no complete UART frame seen on uart_tx_o");
    check_serial(tx_byte, rx_byte);
    check_err("uart_tx_o stop bit", 1'b1, rx_stop);
    apb_access(1'b0, status_addr, '0, rdata, err);
    check_data("prdata of STATUS after frame", 32'h0, rdata);
    check_err("pslverr on STATUS read", 1'b0, err);
  endtask

  // Start bit edge, then each bit sampled at its centre
  initial begin : uart_monitor
    logic [7:0] data;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (helix_pkg::UART_CLKS_PER_BIT / 2) @(negedge clk);
      check_err("uart_tx_o start bit", 1'b0, uart_tx);
      for (int i = 0; i < 8; i++) begin
        repeat (helix_pkg::UART_CLKS_PER_BIT) @(negedge clk);
        data[i] = uart_tx;
      end
      repeat (helix_pkg::UART_CLKS_PER_BIT) @(negedge clk);
      rx_stop = uart_tx;
      rx_byte = data;
      repeat (helix_pkg::UART_CLKS_PER_BIT / 2) @(negedge clk);
      @(posedge clk);
      rx_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_entry(input op_e kind, input logic [helix_pkg::ADDR_W-1:0] addr,
                           input logic [helix_pkg::DATA_W-1:0] wdata, input logic boot,
                           input logic [helix_pkg::DATA_W-1:0] exp_rdata, input logic exp_err);
    table_q.push_back(entry_t'{kind, addr, wdata, boot, exp_rdata, exp_err});
    if (kind == OP_UART)
      uart_entries++;
  endtask

  task automatic build_table();
    logic [helix_pkg::DATA_W-1:0] gpr_a;
    logic [helix_pkg::DATA_W-1:0] gpr_b;
    logic [helix_pkg::ADDR_W-1:0] boot_addr;
    gpr_a     = $urandom();
    gpr_b     = $urandom();
    boot_addr = addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::BOOT_MODE_OFS);
    add_entry(OP_WRITE, addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::GPR0_OFS), gpr_a,
              1'b0, '0, 1'b0);
    add_entry(OP_WRITE, addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::GPR1_OFS), gpr_b,
              1'b0, '0, 1'b0);
    add_entry(OP_READ, addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::GPR0_OFS), '0,
              1'b0, gpr_a, 1'b0);
    add_entry(OP_READ, addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::GPR1_OFS), '0,
              1'b0, gpr_b, 1'b0);
    add_entry(OP_READ, boot_addr, '0, 1'b0, 32'h0, 1'b0);
    add_entry(OP_READ, boot_addr, '0, 1'b1, 32'h1, 1'b0);
    // Read-only status register
    add_entry(OP_WRITE, boot_addr, 32'h0, 1'b1, '0, 1'b1);
    add_entry(OP_READ, boot_addr, '0, 1'b1, 32'h1, 1'b0);
    add_entry(OP_READ, addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::GPR0_OFS), '0,
              1'b1, gpr_a, 1'b0);
    // Unmapped windows and unknown offsets
    add_entry(OP_READ, 32'h4000_2000, '0, 1'b0, 32'h0, 1'b1);
    add_entry(OP_WRITE, 32'h5000_0010, 32'hdead_beef, 1'b0, '0, 1'b1);
    add_entry(OP_READ, addr_of(helix_pkg::SOC_CTRL_BASE, 12'h00c), '0, 1'b0, 32'h0, 1'b1);
    add_entry(OP_READ, addr_of(helix_pkg::UART_BASE, 12'h008), '0, 1'b0, 32'h0, 1'b1);
    add_entry(OP_UART, '0, 32'h0000_00a5, 1'b0, '0, 1'b0);
    add_entry(OP_UART, '0, {24'h0, gpr_b[7:0]}, 1'b0, '0, 1'b0);
  endtask

  task automatic run_entry(input entry_t e);
    logic [helix_pkg::DATA_W-1:0] rdata;
    logic                         err;
    boot_mode = e.boot_mode;
    case (e.kind)
      OP_WRITE: begin
        apb_access(1'b1, e.addr, e.wdata, rdata, err);
        check_err("pslverr", e.exp_err, err);
        if (e.addr == addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::GPR0_OFS))
          check_data("gpr0_o", e.wdata, gpr0);
        if (e.addr == addr_of(helix_pkg::SOC_CTRL_BASE, helix_pkg::GPR1_OFS))
          check_data("gpr1_o", e.wdata, gpr1);
      end
      OP_READ: begin
        apb_access(1'b0, e.addr, '0, rdata, err);
        check_data("prdata", e.exp_rdata, rdata);
        check_err("pslverr", e.exp_err, err);
      end
      default: begin
        send_uart_byte(e.wdata[7:0]);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    apb_req   = '0;
    boot_mode = 1'b0;
    rst_n     = 1'b0;
    void'($urandom(32'hd4933047));
    build_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_data("gpr0_o after reset", '0, gpr0);
    check_data("gpr1_o after reset", '0, gpr1);
    check_err("uart_tx_o after reset", 1'b1, uart_tx);
    check_err("pready with psel low", 1'b0, apb_rsp.pready);
    foreach (table_q[i])
      run_entry(table_q[i]);
    repeat (2) @(negedge clk);
    if (UUT.u_periph_link.handshake_checks.error_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("handshake assertions on the peripheral link failed");
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = table_q.size() * 64 + uart_entries * 12 * helix_pkg::UART_CLKS_PER_BIT + 16;
    repeat (limit) @(posedge clk);
    abort_run($sformatf("timeout, the tests did not finish within %0d cycles", limit));
  end

endmodule

// ==== all.f ====
logic/helix_pkg.sv
logic/apb_slave_port.sv
logic/periph_link.sv
logic/soc_ctrl_regs.sv
logic/uart_tx.sv
logic/periph_soc_top.sv
sim/periph_soc_asserts.sv
sim/periph_soc_tb.sv
